// ==== lease_cache_policy.f ====
hw/lease_pkg.sv
hw/lease_lookup_table.sv
hw/lease_register_file.sv
hw/victim_select.sv
hw/lease_controller.sv
hw/lease_cache_policy.sv
dv/lease_cache_policy_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the lease cache policy testbench with verilator and run it
# a failing check ends in $fatal, which gives a non-zero exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module lease_cache_policy_tb \
	-f lease_cache_policy.f \
	--Mdir obj_dir -o lease_cache_policy_sim

./obj_dir/lease_cache_policy_sim

// ==== dv/lease_cache_policy_tb.sv ====
// ----------------------------------------------------------
// directed table run, set 1 carries most traffic, set 2 the default lease
// expected victims follow the aging rules, lfsr way comes from a model
// ----------------------------------------------------------
`default_nettype none

module lease_cache_policy_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DONE_TIMEOUT = 8;      // cycles allowed for done_o

	typedef enum logic [1:0] {
		OP_CFG,                           // config register write
		OP_LLT,                           // lease table write
		OP_HIT,
		OP_MISS
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [3:0]  a;                   // cache line, or table/config address
		logic [31:0] d;                   // search address, or write data
		logic        swap;
		logic [3:0]  addr;                // victim line, misses only
		logic        expd;
		logic        multi;
		logic        dflt;
		logic        rnd;                 // victim way from the lfsr model
	} row_t;

	logic        clock_i = 1'b0;
	logic        resetn_i;
	logic        con_wren_i;
	logic        llt_wren_i;
	logic [3:0]  llt_addr_i;
	logic [31:0] llt_data_i;
	logic [15:0] llt_search_addr_i;
	logic [3:0]  cache_addr_i;
	logic        hit_i;
	logic        miss_i;
	logic        done_o;
	logic [3:0]  addr_o;
	logic        swap_o;
	logic        expired_o;
	logic        expired_multi_o;
	logic        default_o;
	logic        rand_evict_o;

	row_t        rows[$];
	logic [11:0] lfsr_model;

	always #2 clock_i = ~clock_i;         // 4 ns period

	lease_cache_policy u_lease_cache_policy (
		.clock_i(clock_i), .resetn_i(resetn_i), .con_wren_i(con_wren_i),
		.llt_wren_i(llt_wren_i), .llt_addr_i(llt_addr_i), .llt_data_i(llt_data_i),
		.llt_search_addr_i(llt_search_addr_i), .cache_addr_i(cache_addr_i),
		.hit_i(hit_i), .miss_i(miss_i), .done_o(done_o), .addr_o(addr_o),
		.swap_o(swap_o), .expired_o(expired_o), .expired_multi_o(expired_multi_o),
		.default_o(default_o), .rand_evict_o(rand_evict_o)
	);

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("error: %s expected %0h actual %0h", name, expected, actual);
			$display("Errors found");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input int i);
		$display("row %0d: done_o did not arrive within %0d cycles", i, DONE_TIMEOUT);
		$display("Errors found");
		$fatal(1, "timeout");
	endtask

	// shift left, new bit = b11 ^ b10 ^ b9 ^ b3
	function automatic logic [11:0] advance_lfsr(input logic [11:0] v);
		return {v[10:0], v[11] ^ v[10] ^ v[9] ^ v[3]};
	endfunction

	task automatic add_row(input op_e op, input logic [3:0] a, input logic [31:0] d,
		input logic swap, input logic [3:0] addr, input logic expd, input logic multi,
		input logic dflt, input logic rnd);
		row_t r;
		r = '{op, a, d, swap, addr, expd, multi, dflt, rnd};
		rows.push_back(r);
	endtask

	// ----------------------------------------------------------
	// stimulus table, leases of set 1 noted as {L1 L5 L9 L13}
	// ----------------------------------------------------------
	task automatic build_table();
		// default lease 0, empty table: bypass miss
		add_row(OP_MISS, 4'h1, 32'h0100, 1'b0, 4'h0, 1'b0, 1'b0, 1'b1, 1'b0);
		// entry 0: ref 0x100, lease 5
		add_row(OP_LLT,  4'h0, 32'h0100, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_LLT,  4'h8, 32'd5,    1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		// cold fill of set 1, ways 0..3
		add_row(OP_MISS, 4'h1, 32'h0100, 1'b1, 4'h1, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_HIT,  4'h1, 32'h0100, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_MISS, 4'h1, 32'h0100, 1'b1, 4'h5, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_HIT,  4'h5, 32'h0100, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_MISS, 4'h1, 32'h0100, 1'b1, 4'h9, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_HIT,  4'h9, 32'h0100, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_MISS, 4'h1, 32'h0100, 1'b1, 4'hd, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_HIT,  4'hd, 32'h0100, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);  // {2 3 4 5}
		add_row(OP_HIT,  4'hd, 32'h0100, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);  // {1 2 3 5}
		// miss ages to {0 1 2 4}, only way 0 expired
		add_row(OP_MISS, 4'h1, 32'h0100, 1'b1, 4'h1, 1'b1, 1'b0, 1'b0, 1'b0);
		add_row(OP_HIT,  4'h1, 32'h0100, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);  // {5 1 2 4}
		add_row(OP_HIT,  4'hd, 32'h0100, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);  // {4 0 1 5}
		// miss ages to {3 0 0 4}, ways 1 and 2 expired
		add_row(OP_MISS, 4'h1, 32'h0100, 1'b1, 4'h5, 1'b1, 1'b1, 1'b0, 1'b0);
		add_row(OP_HIT,  4'h5, 32'h0100, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);  // {3 5 0 4}
		add_row(OP_MISS, 4'h1, 32'h0100, 1'b1, 4'h9, 1'b1, 1'b0, 1'b0, 1'b0);
		add_row(OP_HIT,  4'h9, 32'h0100, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);  // {2 4 5 3}
		// entry 1: ref 0x200, lease 100, then renew whole set
		add_row(OP_LLT,  4'h1, 32'h0200, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_LLT,  4'h9, 32'd100,  1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_HIT,  4'h1, 32'h0200, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_HIT,  4'h5, 32'h0200, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_HIT,  4'h9, 32'h0200, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_HIT,  4'hd, 32'h0200, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);  // {97 98 99 100}
		// nothing expired, four random victims
		for (int k = 0; k < 4; k++) begin
			add_row(OP_MISS, 4'h1, 32'h0200, 1'b1, 4'h0, 1'b0, 1'b0, 1'b0, 1'b1);
			add_row(OP_HIT,  4'h1, 32'h0200, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		end
		// default lease 3, set 2 uses it through a table miss
		add_row(OP_CFG,  4'h0, 32'd3,    1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_MISS, 4'h2, 32'h0300, 1'b1, 4'h2, 1'b0, 1'b0, 1'b1, 1'b0);
		add_row(OP_HIT,  4'h2, 32'h0300, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);  // follow-up, no pulse
		add_row(OP_HIT,  4'hd, 32'h0300, 1'b0, 4'h0, 1'b0, 1'b0, 1'b1, 1'b0);  // L13 = 3
		add_row(OP_MISS, 4'h1, 32'h0200, 1'b1, 4'h0, 1'b0, 1'b0, 1'b0, 1'b1);  // L13 = 2
		add_row(OP_HIT,  4'h1, 32'h0200, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_MISS, 4'h1, 32'h0200, 1'b1, 4'h0, 1'b0, 1'b0, 1'b0, 1'b1);  // L13 = 1
		add_row(OP_HIT,  4'h1, 32'h0200, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(OP_MISS, 4'h1, 32'h0200, 1'b1, 4'hd, 1'b1, 1'b0, 1'b0, 1'b0);  // L13 expires
	endtask

	// ----------------------------------------------------------
	// one row: strobe, deassert, then check at the falling edge
	// ----------------------------------------------------------
	task automatic run_row(input int i);
		row_t       r;
		int         waited;
		logic [3:0] exp_addr;
		r = rows[i];
		@(posedge clock_i);
		case (r.op)
			OP_CFG: begin
				con_wren_i <= 1'b1;
				llt_addr_i <= r.a;
				llt_data_i <= r.d;
			end
			OP_LLT: begin
				llt_wren_i <= 1'b1;
				llt_addr_i <= r.a;
				llt_data_i <= r.d;
			end
			default: begin
				hit_i             <= (r.op == OP_HIT);
				miss_i            <= (r.op == OP_MISS);
				cache_addr_i      <= r.a;
				llt_search_addr_i <= r.d[15:0];
			end
		endcase
		@(posedge clock_i);                       // dut takes the strobe here
		con_wren_i <= 1'b0;
		llt_wren_i <= 1'b0;
		hit_i      <= 1'b0;
		miss_i     <= 1'b0;
		@(negedge clock_i);
		check_value($sformatf("row %0d default_o", i), r.dflt, default_o);
		if (r.op != OP_MISS) begin
			check_value($sformatf("row %0d done_o", i), 1'b0, done_o);  // only misses finish
		end else begin
			waited = 0;
			while (!done_o) begin
				if (waited == DONE_TIMEOUT) report_timeout(i);
				@(negedge clock_i);
				waited++;
			end
			exp_addr = r.addr;
			if (r.rnd) begin
				exp_addr   = {lfsr_model[1:0], r.a[1:0]};   // {way, set}
				lfsr_model = advance_lfsr(lfsr_model);
			end
			check_value($sformatf("row %0d swap_o", i), r.swap, swap_o);
			check_value($sformatf("row %0d addr_o", i), exp_addr, addr_o);
			check_value($sformatf("row %0d expired_o", i), r.expd, expired_o);
			check_value($sformatf("row %0d expired_multi_o", i), r.multi, expired_multi_o);
			check_value($sformatf("row %0d rand_evict_o", i), r.rnd, rand_evict_o);
		end
	endtask

	initial begin
		resetn_i          <= 1'b0;
		con_wren_i        <= 1'b0;
		llt_wren_i        <= 1'b0;
		llt_addr_i        <= '0;
		llt_data_i        <= '0;
		llt_search_addr_i <= '0;
		cache_addr_i      <= '0;
		hit_i             <= 1'b0;
		miss_i            <= 1'b0;
		lfsr_model         = 12'hA11;             // matches the dut seed
		build_table();
		repeat (10) @(posedge clock_i);
		resetn_i <= 1'b1;
		@(negedge clock_i);
		// quiet outputs out of reset
		check_value("reset done_o", 1'b0, done_o);
		check_value("reset swap_o", 1'b0, swap_o);
		check_value("reset addr_o", 4'h0, addr_o);
		check_value("reset expired_o", 1'b0, expired_o);
		check_value("reset expired_multi_o", 1'b0, expired_multi_o);
		check_value("reset default_o", 1'b0, default_o);
		check_value("reset rand_evict_o", 1'b0, rand_evict_o);
		for (int i = 0; i < rows.size(); i++) begin
			run_row(i);
		end
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/lease_cache_policy.sv ====
// ----------------------------------------------------------
// wait for done_o after every miss since there is no back-pressure
// config and table writes share llt_addr_i and llt_data_i
// ----------------------------------------------------------
`default_nettype none

module lease_cache_policy (
	input  logic                              clock_i,
	input  logic                              resetn_i,
	input  logic                              con_wren_i,        // config register write
	input  logic                              llt_wren_i,        // lease table write
	input  logic [lease_pkg::LLT_ADDR_BW-1:0] llt_addr_i,
	input  logic [31:0]                       llt_data_i,
	input  logic [lease_pkg::REF_ADDR_BW-1:0] llt_search_addr_i,
	input  logic [lease_pkg::LINE_BW-1:0]     cache_addr_i,
	input  logic                              hit_i,
	input  logic                              miss_i,
	output logic                              done_o,
	output logic [lease_pkg::LINE_BW-1:0]     addr_o,            // victim line
	output logic                              swap_o,
	output logic                              expired_o,
	output logic                              expired_multi_o,
	output logic                              default_o,
	output logic                              rand_evict_o
);

	import lease_pkg::*;

	logic [LEASE_BW-1:0] default_lease_q;
	logic                llt_hit;
	logic [LEASE_BW-1:0] llt_lease;
	logic                dec_all;
	logic                wr;
	logic [LINE_BW-1:0]  wr_line;
	logic [LEASE_BW-1:0] wr_lease;
	logic [N_LINES-1:0]  expired_flags;
	logic                sel;
	logic [SET_BW-1:0]   vs_set;
	logic [WAY_BW-1:0]   vs_way;
	logic                from_expired;
	logic                from_random;
	logic                multi;

	// ----------------------------------------------------------
	// configuration register
	// ----------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			default_lease_q <= '0;
		end else if (con_wren_i && llt_addr_i == CFG_DEFAULT_LEASE) begin
			default_lease_q <= llt_data_i[LEASE_BW-1:0];
		end
	end

	lease_lookup_table u_llt (
		.clock_i(clock_i), .resetn_i(resetn_i), .wren_i(llt_wren_i), .addr_i(llt_addr_i),
		.data_i(llt_data_i), .search_addr_i(llt_search_addr_i), .hit_o(llt_hit), .lease_o(llt_lease)
	);

	lease_register_file u_lrf (
		.clock_i(clock_i), .resetn_i(resetn_i), .dec_all_i(dec_all), .wr_i(wr),
		.wr_line_i(wr_line), .wr_lease_i(wr_lease), .expired_o(expired_flags)
	);

	victim_select u_victim (
		.clock_i(clock_i), .resetn_i(resetn_i), .sel_i(sel), .set_i(vs_set),
		.expired_i(expired_flags), .way_o(vs_way), .from_expired_o(from_expired),
		.from_random_o(from_random), .multi_o(multi)
	);

	lease_controller u_ctrl (
		.clock_i(clock_i), .resetn_i(resetn_i), .hit_i(hit_i), .miss_i(miss_i),
		.cache_addr_i(cache_addr_i), .llt_hit_i(llt_hit), .llt_lease_i(llt_lease),
		.default_lease_i(default_lease_q), .dec_all_o(dec_all), .wr_o(wr), .wr_line_o(wr_line),
		.wr_lease_o(wr_lease), .sel_o(sel), .set_o(vs_set), .way_i(vs_way),
		.from_expired_i(from_expired), .from_random_i(from_random), .multi_i(multi),
		.done_o(done_o), .swap_o(swap_o), .addr_o(addr_o), .expired_o(expired_o),
		.expired_multi_o(expired_multi_o), .default_o(default_o), .rand_evict_o(rand_evict_o)
	);

endmodule

`default_nettype wire

// ==== hw/lease_controller.sv ====
// ----------------------------------------------------------
// hit/miss strobes must not overlap or arrive while a
// victim is being picked; the next hit after an allocating miss is its follow-up
// ----------------------------------------------------------
`default_nettype none

module lease_controller (
	input  logic                           clock_i,
	input  logic                           resetn_i,
	input  logic                           hit_i,
	input  logic                           miss_i,
	input  logic [lease_pkg::LINE_BW-1:0]  cache_addr_i,
	input  logic                           llt_hit_i,
	input  logic [lease_pkg::LEASE_BW-1:0] llt_lease_i,
	input  logic [lease_pkg::LEASE_BW-1:0] default_lease_i,
	output logic                           dec_all_o,
	output logic                           wr_o,
	output logic [lease_pkg::LINE_BW-1:0]  wr_line_o,
	output logic [lease_pkg::LEASE_BW-1:0] wr_lease_o,
	output logic                           sel_o,       // take a victim now
	output logic [lease_pkg::SET_BW-1:0]   set_o,
	input  logic [lease_pkg::WAY_BW-1:0]   way_i,
	input  logic                           from_expired_i,
	input  logic                           from_random_i,
	input  logic                           multi_i,
	output logic                           done_o,
	output logic                           swap_o,
	output logic [lease_pkg::LINE_BW-1:0]  addr_o,
	output logic                           expired_o,
	output logic                           expired_multi_o,
	output logic                           default_o,
	output logic                           rand_evict_o
);

	import lease_pkg::*;

	ctrl_state_e         state_q;
	logic                followup_q;      // next hit only installs saved lease
	logic [LEASE_BW-1:0] saved_lease_q;
	logic [SET_BW-1:0]   set_q;           // set of the allocating miss
	logic [LEASE_BW-1:0] lease_sel;

	assign lease_sel = llt_hit_i ? llt_lease_i : default_lease_i;   // table wins

	// ----------------------------------------------------------
	// register file commands, same cycle as the strobe
	// ----------------------------------------------------------
	always_comb begin
		dec_all_o  = 1'b0;
		wr_o       = 1'b0;
		wr_line_o  = cache_addr_i;
		wr_lease_o = lease_sel;
		if (state_q == ST_NORMAL) begin
			if (hit_i) begin
				wr_o = 1'b1;                        // always renew referenced line
				if (followup_q) wr_lease_o = saved_lease_q;
				else            dec_all_o  = 1'b1;  // miss already aged everyone
			end else if (miss_i) begin
				dec_all_o = 1'b1;
			end
		end
	end

	assign sel_o = (state_q == ST_GEN_ADDR);
	assign set_o = set_q;

	// ----------------------------------------------------------
	// sequencer and result pulses
	// ----------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q         <= ST_NORMAL;
			followup_q      <= 1'b0;
			done_o          <= 1'b0;
			swap_o          <= 1'b0;
			addr_o          <= '0;
			expired_o       <= 1'b0;
			expired_multi_o <= 1'b0;
			default_o       <= 1'b0;
			rand_evict_o    <= 1'b0;
		end else begin
			// pulses fall back by default; addr_o holds
			done_o          <= 1'b0;
			swap_o          <= 1'b0;
			expired_o       <= 1'b0;
			expired_multi_o <= 1'b0;
			default_o       <= 1'b0;
			rand_evict_o    <= 1'b0;
			case (state_q)
				ST_NORMAL: begin
					if (hit_i) begin
						followup_q <= 1'b0;
						default_o  <= !followup_q && !llt_hit_i;
					end else if (miss_i) begin
						default_o <= !llt_hit_i;
						if (lease_sel != '0) begin
							state_q    <= ST_GEN_ADDR;   // line must be allocated
							followup_q <= 1'b1;
						end else begin
							done_o <= 1'b1;              // bypass, swap stays low
						end
					end
				end
				ST_GEN_ADDR: begin
					state_q         <= ST_NORMAL;
					done_o          <= 1'b1;
					swap_o          <= 1'b1;
					addr_o          <= {way_i, set_q};
					expired_o       <= from_expired_i;
					expired_multi_o <= multi_i;
					rand_evict_o    <= from_random_i;
				end
				default: state_q <= ST_NORMAL;
			endcase
		end
	end

	// saved lease and set, only meaningful after an allocating miss
	always_ff @(posedge clock_i) begin
		if (state_q == ST_NORMAL && miss_i && !hit_i) begin
			saved_lease_q <= lease_sel;
			set_q         <= cache_addr_i[SET_BW-1:0];
		end
	end

	a_no_overlap: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(hit_i && miss_i))
		else $error("hit and miss strobes together");

	// cache side has to wait for done_o
	a_no_strobe_pending: assert property (@(posedge clock_i) disable iff (!resetn_i)
		state_q == ST_GEN_ADDR |-> !(hit_i || miss_i))
		else $error("strobe while replacement address pending");

endmodule

`default_nettype wire

// ==== hw/victim_select.sv ====
// ----------------------------------------------------------
// priority: cold-start pointer, lowest expired way, lfsr
// answer is combinational, state moves only on sel_i
// ----------------------------------------------------------
`default_nettype none

module victim_select (
	input  logic                          clock_i,
	input  logic                          resetn_i,
	input  logic                          sel_i,           // victim taken this cycle
	input  logic [lease_pkg::SET_BW-1:0]  set_i,
	input  logic [lease_pkg::N_LINES-1:0] expired_i,       // indexed by line {way, set}
	output logic [lease_pkg::WAY_BW-1:0]  way_o,
	output logic                          from_expired_o,
	output logic                          from_random_o,
	output logic                          multi_o          // two or more expired in set
);

	import lease_pkg::*;

	logic [WAY_BW-1:0] ptr_q [N_SETS];    // next cold fill way per set
	logic [N_SETS-1:0] full_q;
	logic [11:0]       lfsr_q;

	logic [N_WAYS-1:0] set_exp;           // expired flags of the selected set
	logic [WAY_BW-1:0] exp_way;
	logic              any_exp;
	logic              multi_exp;

	// ----------------------------------------------------------
	// expired-way priority encoder
	// ----------------------------------------------------------
	always_comb begin
		exp_way = '0;
		for (int w = 0; w < N_WAYS; w++) begin
			set_exp[w] = expired_i[{WAY_BW'(w), set_i}];
		end
		for (int w = N_WAYS - 1; w >= 0; w--) begin
			if (set_exp[w]) exp_way = WAY_BW'(w);   // lowest one ends up here
		end
	end

	assign any_exp   = |set_exp;
	assign multi_exp = |(set_exp & (set_exp - 1'b1));  // clears lowest bit, anything left?

	// source mux
	always_comb begin
		way_o          = ptr_q[set_i];
		from_expired_o = 1'b0;
		from_random_o  = 1'b0;
		multi_o        = 1'b0;
		if (full_q[set_i]) begin
			if (any_exp) begin
				way_o          = exp_way;
				from_expired_o = 1'b1;
				multi_o        = multi_exp;
			end else begin
				way_o         = lfsr_q[WAY_BW-1:0];
				from_random_o = 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// cold-start pointers and lfsr
	// ----------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int s = 0; s < N_SETS; s++) begin
				ptr_q[s] <= '0;
			end
			full_q <= '0;
			lfsr_q <= LFSR_SEED;
		end else if (sel_i) begin
			if (!full_q[set_i]) begin
				ptr_q[set_i] <= ptr_q[set_i] + 1'b1;
				if (ptr_q[set_i] == WAY_BW'(N_WAYS - 1)) full_q[set_i] <= 1'b1;
			end else if (from_random_o) begin
				// taps 11, 10, 9, 3
				lfsr_q <= {lfsr_q[10:0], lfsr_q[11] ^ lfsr_q[10] ^ lfsr_q[9] ^ lfsr_q[3]};
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/lease_register_file.sv ====
// ----------------------------------------------------------
// one lease counter per line, all cleared by reset
// a write beats the decrement for its own line
// ----------------------------------------------------------
`default_nettype none

module lease_register_file (
	input  logic                           clock_i,
	input  logic                           resetn_i,
	input  logic                           dec_all_i,    // age every live lease by one
	input  logic                           wr_i,         // renew one line
	input  logic [lease_pkg::LINE_BW-1:0]  wr_line_i,
	input  logic [lease_pkg::LEASE_BW-1:0] wr_lease_i,
	output logic [lease_pkg::N_LINES-1:0]  expired_o     // lease at zero
);

	import lease_pkg::*;

	logic [LEASE_BW-1:0] lease_q [N_LINES];

	// ----------------------------------------------------------
	// counters
	// ----------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int i = 0; i < N_LINES; i++) begin
				lease_q[i] <= '0;        // every line starts expired
			end
		end else begin
			for (int i = 0; i < N_LINES; i++) begin
				if (wr_i && wr_line_i == LINE_BW'(i)) begin
					lease_q[i] <= wr_lease_i;
				end else if (dec_all_i && lease_q[i] != '0) begin
					lease_q[i] <= lease_q[i] - 1'b1;   // saturate at zero
				end
			end
		end
	end

	// ----------------------------------------------------------
	// expired flags
	// ----------------------------------------------------------
	always_comb begin
		for (int i = 0; i < N_LINES; i++) begin
			expired_o[i] = (lease_q[i] == '0);
		end
	end

endmodule

`default_nettype wire

// ==== hw/lease_lookup_table.sv ====
// ----------------------------------------------------------
// entry is valid once its reference address is written
// lowest matching entry wins; the lease must be written too
// ----------------------------------------------------------
`default_nettype none

module lease_lookup_table (
	input  logic                              clock_i,
	input  logic                              resetn_i,
	input  logic                              wren_i,        // single cycle write strobe
	input  logic [lease_pkg::LLT_ADDR_BW-1:0] addr_i,        // {table, entry}
	input  logic [31:0]                       data_i,        // word from software
	input  logic [lease_pkg::REF_ADDR_BW-1:0] search_addr_i,
	output logic                              hit_o,
	output logic [lease_pkg::LEASE_BW-1:0]    lease_o
);

	import lease_pkg::*;

	logic [REF_ADDR_BW-1:0]  ref_addr_q [LLT_ENTRIES];
	logic [LEASE_BW-1:0]     lease_q [LLT_ENTRIES];
	logic [LLT_ENTRIES-1:0]  valid_q;
	logic [LLT_ENTRY_BW-1:0] entry;
	llt_table_e              tbl_sel;

	assign entry   = addr_i[LLT_ENTRY_BW-1:0];
	assign tbl_sel = llt_table_e'(addr_i[LLT_ADDR_BW-1]);

	// table contents
	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			if (tbl_sel == TBL_REF_ADDR) ref_addr_q[entry] <= data_i[REF_ADDR_BW-1:0];
			else                         lease_q[entry]    <= data_i[LEASE_BW-1:0];
		end
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (wren_i && tbl_sel == TBL_REF_ADDR) begin
			valid_q[entry] <= 1'b1;    // ref address write arms the entry
		end
	end

	// parallel compare, walk down so the lowest index is left standing
	always_comb begin
		hit_o   = 1'b0;
		lease_o = '0;
		for (int i = LLT_ENTRIES - 1; i >= 0; i--) begin
			if (valid_q[i] && ref_addr_q[i] == search_addr_i) begin
				hit_o   = 1'b1;
				lease_o = lease_q[i];
			end
		end
	end

	// controller branches on this every strobe
	a_hit_known: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!$isunknown(hit_o))
		else $error("lease table hit flag is unknown");

endmodule

`default_nettype wire

// ==== hw/lease_pkg.sv ====
// ----------------------------------------------------------
// geometry is fixed at 16 lines, 4 ways x 4 sets
// line address = {way, set}, so the set is the low bits
// ----------------------------------------------------------
`default_nettype none

package lease_pkg;

	// cache geometry
	localparam int N_LINES = 16;
	localparam int N_WAYS  = 4;
	localparam int N_SETS  = 4;
	localparam int LINE_BW = 4;            // {way, set}
	localparam int WAY_BW  = 2;
	localparam int SET_BW  = 2;

	// lease lookup table
	localparam int LEASE_BW     = 8;
	localparam int LLT_ENTRIES  = 8;
	localparam int LLT_ENTRY_BW = 3;
	localparam int LLT_ADDR_BW  = LLT_ENTRY_BW + 1;   // msb picks the table
	localparam int REF_ADDR_BW  = 16;                 // word address of the reference

	// backup random victim source, 12 bit
	localparam logic [11:0] LFSR_SEED = 12'hA11;

	// config register map, addressed through llt_addr_i
	localparam logic [LLT_ADDR_BW-1:0] CFG_DEFAULT_LEASE = '0;

	typedef enum logic {
		ST_NORMAL   = 1'b0,
		ST_GEN_ADDR = 1'b1    // one cycle to pick a victim
	} ctrl_state_e;

	typedef enum logic {
		TBL_REF_ADDR = 1'b0,
		TBL_LEASE    = 1'b1
	} llt_table_e;

endpackage

`default_nettype wire
